/* rtl/mont_pkg.sv */
`default_nettype none

package mont_pkg;

	// ------------------------------
	// Widths and counters
	// ------------------------------
	localparam int OPW      = 192;            // Operand and result width.
	localparam int EXPW     = 16;             // Exponent width.
	localparam int EXP_IDXW = $clog2(EXPW);   // Width of the exponent bit index.
	localparam int CNTW     = 8;              // Width of the iteration counter.

	localparam logic [CNTW-1:0] ITER_COUNT = CNTW'(OPW); // One iteration per bit of x.

	// ------------------------------
	// Modulus
	// ------------------------------
	// m = 2^192 - 2^64 - 1
	localparam logic [OPW-1:0] MODULUS =
		192'hffffffff_ffffffff_ffffffff_fffffffe_ffffffff_ffffffff;

	localparam logic [OPW:0] NEG_MODULUS = ~{1'b0, MODULUS} + 1'b1; // Adding this subtracts m.

	// ------------------------------
	// Encodings
	// ------------------------------
	typedef enum logic {
		OP_MONT_MUL = 1'b0,
		OP_MOD_EXP  = 1'b1
	} mont_op_e;

	typedef enum logic [2:0] {
		ADDR_A    = 3'd0,
		ADDR_B    = 3'd1,
		ADDR_RMOD = 3'd2,
		ADDR_EXP  = 3'd3,
		ADDR_CMD  = 3'd4
	} reg_addr_e;

	typedef enum logic [1:0] {SEQ_IDLE, SEQ_ISSUE, SEQ_WAIT, SEQ_FINISH} seq_state_e;

	typedef enum logic [1:0] {MULT_IDLE, MULT_RUN, MULT_FINAL} mult_state_e;

endpackage

`default_nettype wire

/* rtl/mont_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mont_if ();
	import mont_pkg::*;

	logic           start; // One-cycle request strobe.
	logic [OPW-1:0] x;     // Held by the requester until done.
	logic [OPW-1:0] y;
	logic [OPW-1:0] z;     // Valid in the cycle done is high.
	logic           done;

	modport requester (
		output start,
		output x,
		output y,
		input  z,
		input  done
	);

	modport core (
		input  start,
		input  x,
		input  y,
		output z,
		output done
	);

endinterface

`default_nettype wire

/* rtl/mont_mult.sv */
`timescale 1ns/1ps
`default_nettype none

module mont_mult (
	input logic    clk,
	input logic    reset,
	mont_if.core   bus
);
	import mont_pkg::*;

	mult_state_e     state;
	logic [CNTW-1:0] count;
	logic [OPW-1:0]  x_sh;     // Multiplier bits, consumed from the LSB.
	logic [OPW:0]    pc;       // Carry half of the running sum.
	logic [OPW:0]    psa;      // Sum half of the running sum.
	logic [OPW-1:0]  z_q;
	logic            done_q;

	logic [OPW:0]    y_by_xi;
	logic [OPW+1:0]  m_ext;
	logic [OPW+1:0]  sum1;
	logic [OPW+1:0]  car1;
	logic [OPW+1:0]  sum2;
	logic [OPW+1:0]  car2;
	logic [OPW:0]    next_pc;
	logic [OPW:0]    next_psa;
	logic [OPW:0]    p;
	logic [OPW:0]    p_minus_m;

	// ------------------------------
	// Carry-save iteration
	// ------------------------------
	assign y_by_xi = {1'b0, bus.y & {OPW{x_sh[0]}}};
	assign m_ext   = {2'b00, MODULUS};

	// First adder folds x_i*y into the redundant pair.
	assign sum1 = {1'b0, pc ^ psa ^ y_by_xi};
	assign car1 = {(pc & psa) | (pc & y_by_xi) | (psa & y_by_xi), 1'b0};

	// Second adder adds m, so an odd sum becomes even.
	assign sum2 = sum1 ^ car1 ^ m_ext;
	assign car2 = {(sum1[OPW:0] & car1[OPW:0]) |
		(sum1[OPW:0] & m_ext[OPW:0]) |
		(car1[OPW:0] & m_ext[OPW:0]), 1'b0};

	// car1 has a zero LSB, so sum1[0] is the parity of the whole sum.
	assign next_pc  = sum1[0] ? car2[OPW+1:1] : car1[OPW+1:1];
	assign next_psa = sum1[0] ? sum2[OPW+1:1] : sum1[OPW+1:1];

	// ------------------------------
	// Final reduction
	// ------------------------------
	assign p         = pc + psa;          // Below 2m.
	assign p_minus_m = p + NEG_MODULUS;   // Top bit set means p < m.

	// ------------------------------
	// Control
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state  <= MULT_IDLE;
			count  <= '0;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state)
				MULT_IDLE: begin
					if (bus.start) begin
						state <= MULT_RUN;
						count <= ITER_COUNT;
					end
				end
				MULT_RUN: begin
					count <= count - 1'b1;
					if (count == CNTW'(1)) begin
						state <= MULT_FINAL; // Last iteration.
					end
				end
				MULT_FINAL: begin
					state  <= MULT_IDLE;
					done_q <= 1'b1;
				end
				default: state <= MULT_IDLE;
			endcase
		end
	end

	// ------------------------------
	// Datapath registers
	// ------------------------------
	always_ff @(posedge clk) begin
		if (state == MULT_IDLE && bus.start) begin
			pc   <= '0;
			psa  <= '0;
			x_sh <= bus.x;
		end else if (state == MULT_RUN) begin
			pc   <= next_pc;
			psa  <= next_psa;
			x_sh <= {1'b0, x_sh[OPW-1:1]};
		end
	end

	always_ff @(posedge clk) begin
		if (state == MULT_FINAL) begin
			z_q <= p_minus_m[OPW] ? p[OPW-1:0] : p_minus_m[OPW-1:0];
		end
	end

	assign bus.z    = z_q;
	assign bus.done = done_q;

	// A new request only arrives once the previous product has been returned.
	a_start_idle: assert property (@(posedge clk) disable iff (reset)
		bus.start |-> state == MULT_IDLE);

	// The returned product is fully reduced.
	a_z_reduced: assert property (@(posedge clk) disable iff (reset)
		bus.done |-> bus.z < MODULUS);

endmodule

`default_nettype wire

/* rtl/mont_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module mont_regs (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      wr_en,
	input  mont_pkg::reg_addr_e       wr_addr,
	input  logic [mont_pkg::OPW-1:0]  wr_data,
	input  logic                      seq_done,
	output logic                      go,
	output mont_pkg::mont_op_e        op,
	output logic [mont_pkg::OPW-1:0]  a,
	output logic [mont_pkg::OPW-1:0]  b,
	output logic [mont_pkg::OPW-1:0]  r_mod,
	output logic [mont_pkg::EXPW-1:0] exp,
	output logic                      busy
);
	import mont_pkg::*;

	logic accept;

	assign accept = wr_en && !busy;                 // Writes during a run are dropped.
	assign go     = accept && (wr_addr == ADDR_CMD);

	// ------------------------------
	// Operand registers
	// ------------------------------
	always_ff @(posedge clk) begin
		if (accept) begin
			case (wr_addr)
				ADDR_A:    a     <= wr_data;
				ADDR_B:    b     <= wr_data;
				ADDR_RMOD: r_mod <= wr_data;
				ADDR_EXP:  exp   <= wr_data[EXPW-1:0];
				ADDR_CMD:  op    <= mont_op_e'(wr_data[0]); // Valid from the cycle after go.
				default: ;
			endcase
		end
	end

	// ------------------------------
	// Status
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
		end else if (go) begin
			busy <= 1'b1;
		end else if (seq_done) begin
			busy <= 1'b0;
		end
	end

	// The sequencer only reports completion of a command that is running.
	a_done_while_busy: assert property (@(posedge clk) disable iff (reset)
		seq_done |-> busy);

endmodule

`default_nettype wire

/* rtl/modexp_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module modexp_seq (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      go,
	input  mont_pkg::mont_op_e        op,
	input  logic [mont_pkg::OPW-1:0]  a,
	input  logic [mont_pkg::OPW-1:0]  b,
	input  logic [mont_pkg::OPW-1:0]  r_mod,
	input  logic [mont_pkg::EXPW-1:0] exp,
	mont_if.requester                 mm,
	output logic [mont_pkg::OPW-1:0]  result,
	output logic                      done
);
	import mont_pkg::*;

	seq_state_e          state;
	logic [OPW-1:0]      acc;       // Montgomery-domain accumulator.
	logic [EXP_IDXW-1:0] bit_idx;   // Exponent bit being processed.
	logic                mul_phase; // Set when the pending product is the multiply by a.
	logic                is_mul;
	logic                no_products;

	assign is_mul      = (op == OP_MONT_MUL);
	assign no_products = !is_mul && (exp == '0); // A zero exponent returns r_mod.

	// ------------------------------
	// Product request
	// ------------------------------
	assign mm.start = (state == SEQ_ISSUE) && !no_products;
	assign mm.x     = is_mul ? a : acc;
	assign mm.y     = is_mul ? b : (mul_phase ? a : acc);

	assign result = acc;
	assign done   = (state == SEQ_FINISH);

	// ------------------------------
	// State machine
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= SEQ_IDLE;
			bit_idx   <= '0;
			mul_phase <= 1'b0;
		end else begin
			case (state)
				SEQ_IDLE: begin
					if (go) begin
						state     <= SEQ_ISSUE;
						bit_idx   <= EXP_IDXW'(EXPW - 1); // Start at the MSB.
						mul_phase <= 1'b0;
					end
				end
				SEQ_ISSUE: state <= no_products ? SEQ_FINISH : SEQ_WAIT;
				SEQ_WAIT: begin
					if (mm.done) begin
						if (is_mul) begin
							state <= SEQ_FINISH;
						end else if (!mul_phase && exp[bit_idx]) begin
							mul_phase <= 1'b1; // Square done, the bit asks for a multiply.
							state     <= SEQ_ISSUE;
						end else begin
							mul_phase <= 1'b0;
							if (bit_idx == '0) begin
								state <= SEQ_FINISH;
							end else begin
								bit_idx <= bit_idx - 1'b1;
								state   <= SEQ_ISSUE;
							end
						end
					end
				end
				SEQ_FINISH: state <= SEQ_IDLE;
				default:    state <= SEQ_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == SEQ_IDLE && go) begin
			acc <= r_mod;
		end else if (state == SEQ_WAIT && mm.done) begin
			acc <= mm.z;
		end
	end

	// The core only answers a request that is still outstanding.
	a_done_in_wait: assert property (@(posedge clk) disable iff (reset)
		mm.done |-> state == SEQ_WAIT);

endmodule

`default_nettype wire

/* rtl/modexp_top.sv */
`timescale 1ns/1ps
`default_nettype none

module modexp_top (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     wr_en,
	input  mont_pkg::reg_addr_e      wr_addr,
	input  logic [mont_pkg::OPW-1:0] wr_data,
	output logic [mont_pkg::OPW-1:0] result,
	output logic                     busy,
	output logic                     done
);
	import mont_pkg::*;

	logic            go;
	mont_op_e        op;
	logic [OPW-1:0]  a;
	logic [OPW-1:0]  b;
	logic [OPW-1:0]  r_mod;
	logic [EXPW-1:0] exp;

	mont_if mm ();

	mont_regs u_regs (
		.clk      (clk),
		.reset    (reset),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.seq_done (done),
		.go       (go),
		.op       (op),
		.a        (a),
		.b        (b),
		.r_mod    (r_mod),
		.exp      (exp),
		.busy     (busy)
	);

	modexp_seq u_seq (
		.clk    (clk),
		.reset  (reset),
		.go     (go),
		.op     (op),
		.a      (a),
		.b      (b),
		.r_mod  (r_mod),
		.exp    (exp),
		.mm     (mm.requester),
		.result (result),
		.done   (done)
	);

	mont_mult u_mult (
		.clk   (clk),
		.reset (reset),
		.bus   (mm.core)
	);

endmodule

`default_nettype wire

/* verif/modexp_ref.svh */
`ifndef MODEXP_REF_SVH
`define MODEXP_REF_SVH

// ------------------------------
// Reference model
// ------------------------------

// Montgomery product x*y*2^-OPW mod m, one bit of x per step.
// The running value stays below 2m, so OPW+2 bits never overflow.
function automatic logic [OPW-1:0] ref_mont_mul(input logic [OPW-1:0] x,
	input logic [OPW-1:0] y);
	logic [OPW+1:0] t;
	logic [OPW+1:0] m_wide;
	m_wide = {2'b00, MODULUS};
	t      = '0;
	for (int i = 0; i < OPW; i++) begin
		if (x[i]) begin
			t = t + {2'b00, y};
		end
		if (t[0]) begin
			t = t + m_wide; // Makes the sum even.
		end
		t = t >> 1;
	end
	if (t >= m_wide) begin
		t = t - m_wide;
	end
	return t[OPW-1:0];
endfunction

// Left-to-right square-and-multiply in the Montgomery domain.
function automatic logic [OPW-1:0] ref_mod_exp(input logic [OPW-1:0] base,
	input logic [OPW-1:0] r_mod, input logic [EXPW-1:0] e);
	logic [OPW-1:0] acc;
	acc = r_mod; // Montgomery form of one.
	for (int i = EXPW - 1; i >= 0; i--) begin
		acc = ref_mont_mul(acc, acc);
		if (e[i]) begin
			acc = ref_mont_mul(acc, base);
		end
	end
	return acc;
endfunction

`endif

/* verif/modexp_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module modexp_tb;
	import mont_pkg::*;

	`include "modexp_ref.svh"

	localparam int unsigned SEED         = 97639;
	localparam int unsigned RESET_CYCLES = 16;
	localparam int unsigned MAX_CYCLES   = 120000; // 13 commands of up to 32 products.
	localparam int unsigned MUL_LATENCY  = 196;    // Command strobe to done.

	// 2^192 mod m, the Montgomery form of one.
	localparam logic [OPW-1:0] R_VALUE =
		192'h00000000_00000000_00000000_00000001_00000000_00000001;

	logic            clk;
	logic            reset;
	logic            wr_en;
	reg_addr_e       wr_addr;
	logic [OPW-1:0]  wr_data;
	logic [OPW-1:0]  result;
	logic            busy;
	logic            done;

	int unsigned     cycle_count = 0;
	logic [OPW-1:0]  expect_q[$];
	int unsigned     latency_q[$]; // Zero when the latency is not checked.

	modexp_top dut_i (
		.clk     (clk),
		.reset   (reset),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.result  (result),
		.busy    (busy),
		.done    (done)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, the DUT never finished.", cycle_count);
			$display("TEST FAIL");
			$fatal(1, "Simulation timeout");
		end
	end

	// ------------------------------
	// Helpers
	// ------------------------------
	task automatic check_value(input string name, input logic [OPW-1:0] got,
		input logic [OPW-1:0] want);
		if (got !== want) begin
			$display("** Error at %0d ns: %s = 0x%h, expected 0x%h", $time, name, got, want);
			$display("TEST FAIL");
			$fatal(1, "Value mismatch on %s", name);
		end
	endtask

	function automatic logic [OPW-1:0] rand_operand();
		logic [OPW-1:0] v;
		for (int i = 0; i < OPW / 32; i++) begin
			v[i*32 +: 32] = $urandom();
		end
		if (v >= MODULUS) begin
			v = v - MODULUS; // One step suffices, v is below 2m.
		end
		return v;
	endfunction

	task automatic write_reg(input reg_addr_e addr, input logic [OPW-1:0] data);
		@(posedge clk);
		wr_en   <= 1'b1;
		wr_addr <= addr;
		wr_data <= data;
	endtask

	// Busy must be low in the strobe cycle and high in the next one.
	task automatic issue_cmd(input mont_op_e op);
		write_reg(ADDR_CMD, OPW'(op));
		@(negedge clk);
		check_value("busy", OPW'(busy), '0);
		@(posedge clk);
		wr_en <= 1'b0;
		@(negedge clk);
		check_value("busy", OPW'(busy), OPW'(1));
	endtask

	task automatic wait_done();
		do begin
			@(negedge clk);
		end while (!done);
		@(posedge clk);
	endtask

	task automatic run_mul(input logic [OPW-1:0] x, input logic [OPW-1:0] y, input bit timed);
		write_reg(ADDR_A, x);
		write_reg(ADDR_B, y);
		expect_q.push_back(ref_mont_mul(x, y));
		latency_q.push_back(timed ? MUL_LATENCY : 32'd0);
		issue_cmd(OP_MONT_MUL);
		wait_done();
	endtask

	task automatic run_exp(input logic [OPW-1:0] base, input logic [EXPW-1:0] e);
		write_reg(ADDR_A, base);
		write_reg(ADDR_RMOD, R_VALUE);
		write_reg(ADDR_EXP, OPW'(e));
		expect_q.push_back(ref_mod_exp(base, R_VALUE, e));
		latency_q.push_back(32'd0);
		issue_cmd(OP_MOD_EXP);
		wait_done();
	endtask

	// Operand and command writes during a run must leave the product untouched.
	task automatic run_busy_writes();
		logic [OPW-1:0] x;
		logic [OPW-1:0] y;
		x = rand_operand();
		y = rand_operand();
		write_reg(ADDR_A, x);
		write_reg(ADDR_B, y);
		expect_q.push_back(ref_mont_mul(x, y));
		latency_q.push_back(MUL_LATENCY);
		issue_cmd(OP_MONT_MUL);
		write_reg(ADDR_A, rand_operand());
		write_reg(ADDR_B, rand_operand());
		write_reg(ADDR_CMD, OPW'(OP_MOD_EXP));
		@(posedge clk);
		wr_en <= 1'b0;
		wait_done();
		// A repeat without new operands shows that a and b kept their values.
		expect_q.push_back(ref_mont_mul(x, y));
		latency_q.push_back(32'd0);
		issue_cmd(OP_MONT_MUL);
		wait_done();
	endtask

	// ------------------------------
	// Compare process
	// ------------------------------
	initial begin : compare_results
		int unsigned    cmd_cycle;
		int unsigned    want_lat;
		logic [OPW-1:0] want;
		cmd_cycle = 0;
		forever begin
			@(negedge clk);
			if (!reset && wr_en && wr_addr == ADDR_CMD && !busy) begin
				cmd_cycle = cycle_count; // Accepted command strobe.
			end
			if (!reset && done) begin
				if (expect_q.size() == 0) begin
					$display("A done strobe arrived at %0d ns with no command pending.", $time);
					$display("TEST FAIL");
					$fatal(1, "Unexpected done");
				end else begin
					want     = expect_q.pop_front();
					want_lat = latency_q.pop_front();
					check_value("result", result, want);
					if (want_lat != 0) begin
						check_value("done latency", OPW'(cycle_count - cmd_cycle), OPW'(want_lat));
					end
				end
			end
		end
	end

	// ------------------------------
	// Stimulus
	// ------------------------------
	initial begin
		reset   = 1'b1;
		wr_en   = 1'b0;
		wr_addr = ADDR_A;
		wr_data = '0;
		void'($urandom(SEED));
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value("busy", OPW'(busy), '0);
		check_value("done", OPW'(done), '0);

		run_mul('0, R_VALUE, 1'b1);
		run_mul(OPW'(1), R_VALUE, 1'b1);
		run_mul(MODULUS - 1, MODULUS - 1, 1'b1);
		run_mul(R_VALUE, R_VALUE, 1'b1);
		repeat (2) run_mul(rand_operand(), rand_operand(), 1'b0);

		run_exp(rand_operand(), '0);
		run_exp(rand_operand(), EXPW'(1));
		repeat (3) run_exp(rand_operand(), EXPW'($urandom()));

		run_busy_writes();
		repeat (400) @(posedge clk); // Leaves room for a stray done to show up.

		if (expect_q.size() != 0) begin
			$display("%0d commands never signalled done.", expect_q.size());
			$display("TEST FAIL");
			$fatal(1, "Missing done");
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+verif
rtl/mont_pkg.sv
rtl/mont_if.sv
rtl/mont_mult.sv
rtl/mont_regs.sv
rtl/modexp_seq.sv
rtl/modexp_top.sv
verif/modexp_tb.sv

/* Makefile */
# Verilator flow for the Montgomery exponentiation engine.

VERILATOR  ?= verilator
TOP        ?= modexp_tb
FILELIST   ?= sim.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run's exit status is the test result.
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
